/* axi_bridge_pkg.sv */
package axi_bridge_pkg;

    // who currently holds the shared AXI port
    typedef enum logic [1:0] {
        OWN_NONE    = 2'd0,
        OWN_IFETCH  = 2'd1,
        OWN_DATA_RD = 2'd2,
        OWN_DATA_WR = 2'd3
    } bus_owner_e;

    // transaction IDs per client
    localparam logic [3:0] ID_IFETCH = 4'd0;
    localparam logic [3:0] ID_DATA   = 4'd1;

    // instruction fetches are marked as instruction accesses
    localparam logic [2:0] PROT_IFETCH = 3'b100;
    localparam logic [2:0] PROT_DATA   = 3'b000;

    // 4-byte beats
    localparam logic [2:0] SIZE_WORD = 3'b010;

    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

/* bus_ctrl_if.sv */
`timescale 1ns/1ns

interface bus_ctrl_if import axi_bridge_pkg::*; #(
    parameter int LEN_W = 8
) ();

    bus_owner_e         owner;
    logic               start;
    logic [LEN_W-1:0]   start_len;
    logic               beat;
    logic               done;

    modport fsm (
        output owner,
        output start,
        output start_len,
        input  done
    );

    modport counter (
        input  owner,
        input  start,
        input  start_len,
        input  beat,
        output done
    );

    modport router (
        input  owner,
        input  done,
        output beat
    );

endinterface

/* chan_hold.sv */
`timescale 1ns/1ns

module chan_hold #(
    parameter type T = logic
) (
    input  logic aclk,
    input  logic aresetn,
    input  logic i_load,
    input  T     i_payload,
    input  logic i_ready,
    output logic o_valid,
    output T     o_payload
);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_valid <= 1'b0;
        end else if (i_load) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_load) begin
            o_payload <= i_payload;
        end
    end

    no_load_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        i_load |-> !o_valid);

    // valid and payload hold until the handshake
    hold_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (o_valid && !i_ready) |=> o_valid && $stable(o_payload));

endmodule

/* beat_counter.sv */
`timescale 1ns/1ns

module beat_counter import axi_bridge_pkg::*; #(
    parameter int LEN_W = 8
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        i_rlast,
    bus_ctrl_if.counter bus
);

    logic [LEN_W-1:0] remain;
    logic             counted;

    assign counted = bus.beat && (bus.owner != OWN_NONE);

    // beats left after the current one
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            remain <= '0;
        end else if (bus.start) begin
            remain <= bus.start_len;
        end else if (counted) begin
            remain <= remain - 1'b1;
        end
    end

    assign bus.done = counted && (remain == '0);

    // slave framing must agree with the length we requested
    rlast_match: assert property (@(posedge aclk) disable iff (!aresetn)
        counted |-> (i_rlast == bus.done));

endmodule

/* read_router.sv */
`timescale 1ns/1ns

module read_router import axi_bridge_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              i_rvalid,
    input  logic [3:0]        i_rid,
    input  logic [DATA_W-1:0] i_rdata,
    input  logic [1:0]        i_rresp,
    output logic              o_rready,
    output logic              o_if_valid,
    output logic [DATA_W-1:0] o_if_data,
    output logic              o_if_last,
    output logic              o_drd_valid,
    output logic [DATA_W-1:0] o_drd_data,
    bus_ctrl_if.router        bus
);

    logic       rd_hs;
    logic [3:0] exp_id;

    // clients cannot stall returned data
    assign o_rready = (bus.owner == OWN_IFETCH) || (bus.owner == OWN_DATA_RD);
    assign rd_hs    = i_rvalid && o_rready;
    assign bus.beat = rd_hs;

    assign o_if_valid = rd_hs && (bus.owner == OWN_IFETCH);
    assign o_if_data  = i_rdata;
    assign o_if_last  = o_if_valid && bus.done;

    assign o_drd_valid = rd_hs && (bus.owner == OWN_DATA_RD);
    assign o_drd_data  = i_rdata;

    assign exp_id = (bus.owner == OWN_IFETCH) ? ID_IFETCH : ID_DATA;

    // beat must belong to the transaction we issued
    rid_owner: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_hs |-> (i_rid == exp_id) && (i_rresp == RESP_OKAY));

endmodule

/* bus_owner_fsm.sv */
`timescale 1ns/1ns

module bus_owner_fsm import axi_bridge_pkg::*; #(
    parameter int  ADDR_W   = 32,
    parameter int  DATA_W   = 32,
    parameter int  LEN_W    = 8,
    parameter int  IF_BEATS = 16,
    parameter type areq_t   = logic,
    parameter type wbeat_t  = logic
) (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                i_if_req,
    input  logic [ADDR_W-1:0]   i_if_addr,
    input  logic                i_drd_req,
    input  logic [ADDR_W-1:0]   i_drd_addr,
    input  logic [2:0]          i_drd_size,
    input  logic                i_dwr_req,
    input  logic [ADDR_W-1:0]   i_dwr_addr,
    input  logic [DATA_W-1:0]   i_dwr_data,
    input  logic [DATA_W/8-1:0] i_dwr_strb,
    input  logic                i_ar_accept,
    input  logic                i_aw_accept,
    input  logic                i_w_accept,
    input  logic                i_bvalid,
    output logic                o_if_rdy,
    output logic                o_drd_rdy,
    output logic                o_dwr_rdy,
    output logic                o_ar_load,
    output areq_t               o_ar_req,
    output logic                o_aw_load,
    output areq_t               o_aw_req,
    output logic                o_w_load,
    output wbeat_t              o_w_beat,
    output logic                o_bready,
    output logic                o_dwr_done,
    bus_ctrl_if.fsm             bus
);

    typedef enum logic [2:0] {
        IDLE,
        RD_ADDR,
        RD_DATA,
        WR_ADDR,
        WR_RESP
    } state_e;

    state_e state;
    logic   aw_seen;
    logic   w_seen;

    // the rdy pulse doubles as the load strobe of the matching channels
    assign o_ar_load = o_if_rdy || o_drd_rdy;
    assign o_aw_load = o_dwr_rdy;
    assign o_w_load  = o_dwr_rdy;

    assign bus.start     = (state == RD_ADDR) && i_ar_accept;
    assign bus.start_len = o_ar_req.len;

    assign o_bready   = (state == WR_RESP);
    assign o_dwr_done = o_bready && i_bvalid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state     <= IDLE;
            bus.owner <= OWN_NONE;
            o_if_rdy  <= 1'b0;
            o_drd_rdy <= 1'b0;
            o_dwr_rdy <= 1'b0;
            aw_seen   <= 1'b0;
            w_seen    <= 1'b0;
        end else begin
            o_if_rdy  <= 1'b0;
            o_drd_rdy <= 1'b0;
            o_dwr_rdy <= 1'b0;
            case (state)
                IDLE: begin
                    aw_seen <= 1'b0;
                    w_seen  <= 1'b0;
                    // writes first, then data reads, then fetch
                    if (i_dwr_req) begin
                        state     <= WR_ADDR;
                        bus.owner <= OWN_DATA_WR;
                        o_dwr_rdy <= 1'b1;
                    end else if (i_drd_req) begin
                        state     <= RD_ADDR;
                        bus.owner <= OWN_DATA_RD;
                        o_drd_rdy <= 1'b1;
                    end else if (i_if_req) begin
                        state     <= RD_ADDR;
                        bus.owner <= OWN_IFETCH;
                        o_if_rdy  <= 1'b1;
                    end
                end
                RD_ADDR: begin
                    if (i_ar_accept) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (bus.done) begin
                        state     <= IDLE;
                        bus.owner <= OWN_NONE;
                    end
                end
                WR_ADDR: begin
                    if (i_aw_accept) begin
                        aw_seen <= 1'b1;
                    end
                    if (i_w_accept) begin
                        w_seen <= 1'b1;
                    end
                    // AW and W may be accepted in either order
                    if ((aw_seen || i_aw_accept) && (w_seen || i_w_accept)) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (i_bvalid) begin
                        state     <= IDLE;
                        bus.owner <= OWN_NONE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // channel payloads captured on the grant edge
    always_ff @(posedge aclk) begin
        if (state == IDLE) begin
            if (i_dwr_req) begin
                o_aw_req.addr <= i_dwr_addr;
                o_aw_req.len  <= '0;
                o_aw_req.size <= SIZE_WORD;
                o_aw_req.id   <= ID_DATA;
                o_aw_req.prot <= PROT_DATA;
                o_w_beat.data <= i_dwr_data;
                o_w_beat.strb <= i_dwr_strb;
            end else if (i_drd_req) begin
                o_ar_req.addr <= i_drd_addr;
                o_ar_req.len  <= '0;
                o_ar_req.size <= i_drd_size;
                o_ar_req.id   <= ID_DATA;
                o_ar_req.prot <= PROT_DATA;
            end else if (i_if_req) begin
                o_ar_req.addr <= i_if_addr;
                o_ar_req.len  <= LEN_W'(IF_BEATS - 1);
                o_ar_req.size <= SIZE_WORD;
                o_ar_req.id   <= ID_IFETCH;
                o_ar_req.prot <= PROT_IFETCH;
            end
        end
    end

    // ownership only moves when entering or leaving IDLE
    owner_locked: assert property (@(posedge aclk) disable iff (!aresetn)
        (state != IDLE) |=> (state == IDLE) || $stable(bus.owner));

endmodule

/* core_axi_bridge.sv */
`timescale 1ns/1ns

module core_axi_bridge import axi_bridge_pkg::*; #(
    parameter int ADDR_W   = 32,
    parameter int DATA_W   = 32,
    parameter int IF_BEATS = 16,
    parameter int LEN_W    = 8
) (
    input  logic                aclk,
    input  logic                aresetn,
    // instruction fetch
    input  logic                i_if_req,
    input  logic [ADDR_W-1:0]   i_if_addr,
    output logic                o_if_rdy,
    output logic                o_if_valid,
    output logic [DATA_W-1:0]   o_if_data,
    output logic                o_if_last,
    // data read
    input  logic                i_drd_req,
    input  logic [ADDR_W-1:0]   i_drd_addr,
    input  logic [2:0]          i_drd_size,
    output logic                o_drd_rdy,
    output logic                o_drd_valid,
    output logic [DATA_W-1:0]   o_drd_data,
    // data write
    input  logic                i_dwr_req,
    input  logic [ADDR_W-1:0]   i_dwr_addr,
    input  logic [DATA_W-1:0]   i_dwr_data,
    input  logic [DATA_W/8-1:0] i_dwr_strb,
    output logic                o_dwr_rdy,
    output logic                o_dwr_done,
    // AXI read
    output logic [3:0]          o_arid,
    output logic [ADDR_W-1:0]   o_araddr,
    output logic [LEN_W-1:0]    o_arlen,
    output logic [2:0]          o_arsize,
    output logic [2:0]          o_arprot,
    output logic                o_arvalid,
    input  logic                i_arready,
    input  logic [3:0]          i_rid,
    input  logic [DATA_W-1:0]   i_rdata,
    input  logic [1:0]          i_rresp,
    input  logic                i_rlast,
    input  logic                i_rvalid,
    output logic                o_rready,
    // AXI write
    output logic [ADDR_W-1:0]   o_awaddr,
    output logic [LEN_W-1:0]    o_awlen,
    output logic                o_awvalid,
    input  logic                i_awready,
    output logic [DATA_W-1:0]   o_wdata,
    output logic [DATA_W/8-1:0] o_wstrb,
    output logic                o_wlast,
    output logic                o_wvalid,
    input  logic                i_wready,
    input  logic [1:0]          i_bresp,
    input  logic                i_bvalid,
    output logic                o_bready
);

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [3:0]        id;
        logic [2:0]        prot;
    } addr_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
    } wbeat_t;

    addr_req_t ar_req;
    addr_req_t ar_held;
    addr_req_t aw_req;
    addr_req_t aw_held;
    wbeat_t    w_beat;
    wbeat_t    w_held;
    logic      ar_load;
    logic      aw_load;
    logic      w_load;

    bus_ctrl_if #(.LEN_W(LEN_W)) u_bus ();

    bus_owner_fsm #(
        .ADDR_W   (ADDR_W),
        .DATA_W   (DATA_W),
        .LEN_W    (LEN_W),
        .IF_BEATS (IF_BEATS),
        .areq_t   (addr_req_t),
        .wbeat_t  (wbeat_t)
    ) u_fsm (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_if_req    (i_if_req),
        .i_if_addr   (i_if_addr),
        .i_drd_req   (i_drd_req),
        .i_drd_addr  (i_drd_addr),
        .i_drd_size  (i_drd_size),
        .i_dwr_req   (i_dwr_req),
        .i_dwr_addr  (i_dwr_addr),
        .i_dwr_data  (i_dwr_data),
        .i_dwr_strb  (i_dwr_strb),
        .i_ar_accept (o_arvalid && i_arready),
        .i_aw_accept (o_awvalid && i_awready),
        .i_w_accept  (o_wvalid && i_wready),
        .i_bvalid    (i_bvalid),
        .o_if_rdy    (o_if_rdy),
        .o_drd_rdy   (o_drd_rdy),
        .o_dwr_rdy   (o_dwr_rdy),
        .o_ar_load   (ar_load),
        .o_ar_req    (ar_req),
        .o_aw_load   (aw_load),
        .o_aw_req    (aw_req),
        .o_w_load    (w_load),
        .o_w_beat    (w_beat),
        .o_bready    (o_bready),
        .o_dwr_done  (o_dwr_done),
        .bus         (u_bus.fsm)
    );

    beat_counter #(.LEN_W(LEN_W)) u_counter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_rlast (i_rlast),
        .bus     (u_bus.counter)
    );

    read_router #(.DATA_W(DATA_W)) u_router (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_rvalid    (i_rvalid),
        .i_rid       (i_rid),
        .i_rdata     (i_rdata),
        .i_rresp     (i_rresp),
        .o_rready    (o_rready),
        .o_if_valid  (o_if_valid),
        .o_if_data   (o_if_data),
        .o_if_last   (o_if_last),
        .o_drd_valid (o_drd_valid),
        .o_drd_data  (o_drd_data),
        .bus         (u_bus.router)
    );

    chan_hold #(.T(addr_req_t)) u_ar_hold (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_load    (ar_load),
        .i_payload (ar_req),
        .i_ready   (i_arready),
        .o_valid   (o_arvalid),
        .o_payload (ar_held)
    );

    chan_hold #(.T(addr_req_t)) u_aw_hold (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_load    (aw_load),
        .i_payload (aw_req),
        .i_ready   (i_awready),
        .o_valid   (o_awvalid),
        .o_payload (aw_held)
    );

    chan_hold #(.T(wbeat_t)) u_w_hold (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_load    (w_load),
        .i_payload (w_beat),
        .i_ready   (i_wready),
        .o_valid   (o_wvalid),
        .o_payload (w_held)
    );

    assign o_arid   = ar_held.id;
    assign o_araddr = ar_held.addr;
    assign o_arlen  = ar_held.len;
    assign o_arsize = ar_held.size;
    assign o_arprot = ar_held.prot;

    assign o_awaddr = aw_held.addr;
    assign o_awlen  = aw_held.len;
    assign o_wdata  = w_held.data;
    assign o_wstrb  = w_held.strb;
    // single-beat writes
    assign o_wlast  = o_wvalid;

    bresp_okay: assert property (@(posedge aclk) disable iff (!aresetn)
        (i_bvalid && o_bready) |-> (i_bresp == RESP_OKAY));

endmodule

/* tb_core_axi_bridge.sv */
`timescale 1ns/1ns

module tb_core_axi_bridge;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int IF_BEATS = 16;
    localparam int LEN_W    = 8;
    localparam logic [LEN_W-1:0] FETCH_LEN = LEN_W'(IF_BEATS - 1);
    localparam logic [31:0]      RD_MASK   = 32'h5a5a_0000;

    typedef struct packed {
        byte         kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [2:0]  size;
    } txn_t;

    logic              aclk;
    logic              aresetn;
    logic              i_if_req;
    logic [ADDR_W-1:0] i_if_addr;
    logic              o_if_rdy;
    logic              o_if_valid;
    logic [DATA_W-1:0] o_if_data;
    logic              o_if_last;
    logic              i_drd_req;
    logic [ADDR_W-1:0] i_drd_addr;
    logic [2:0]        i_drd_size;
    logic              o_drd_rdy;
    logic              o_drd_valid;
    logic [DATA_W-1:0] o_drd_data;
    logic              i_dwr_req;
    logic [ADDR_W-1:0] i_dwr_addr;
    logic [DATA_W-1:0] i_dwr_data;
    logic [3:0]        i_dwr_strb;
    logic              o_dwr_rdy;
    logic              o_dwr_done;
    logic [3:0]        o_arid;
    logic [ADDR_W-1:0] o_araddr;
    logic [LEN_W-1:0]  o_arlen;
    logic [2:0]        o_arsize;
    logic [2:0]        o_arprot;
    logic              o_arvalid;
    logic              i_arready;
    logic [3:0]        i_rid;
    logic [DATA_W-1:0] i_rdata;
    logic [1:0]        i_rresp;
    logic              i_rlast;
    logic              i_rvalid;
    logic              o_rready;
    logic [ADDR_W-1:0] o_awaddr;
    logic [LEN_W-1:0]  o_awlen;
    logic              o_awvalid;
    logic              i_awready;
    logic [DATA_W-1:0] o_wdata;
    logic [3:0]        o_wstrb;
    logic              o_wlast;
    logic              o_wvalid;
    logic              i_wready;
    logic [1:0]        i_bresp;
    logic              i_bvalid;
    logic              o_bready;

    txn_t        tests[$];
    txn_t        exp_q[$];
    txn_t        cur;
    txn_t        wr_cur;
    int          errors;
    int          n_done;
    int          n_lines;
    int          n_writes;
    int          n_fetches;
    int          fetch_beats;
    int          dwr_done_cnt;
    int          beat_idx;
    logic [31:0] exp_rd;
    logic        exp_last;

    // slave model state updated at the falling edge
    logic        ar_hs;
    logic        r_hs;
    logic        aw_hs;
    logic        w_hs;
    logic        b_hs;
    logic        ar_stall;
    logic        aw_stall;
    logic [49:0] ar_snap;
    logic [39:0] aw_snap;
    logic [31:0] rd_addr;
    logic [3:0]  rd_id;
    int          rd_left;
    int          ar_wait;
    int          aw_wait;
    int          w_wait;
    int          r_wait;
    int          b_wait;
    logic        aw_got;
    logic        w_got;
    logic        b_pend;
    logic [31:0] aw_rec;
    logic [31:0] w_data_rec;
    logic [3:0]  w_strb_rec;

    core_axi_bridge #(
        .ADDR_W   (ADDR_W),
        .DATA_W   (DATA_W),
        .IF_BEATS (IF_BEATS),
        .LEN_W    (LEN_W)
    ) u_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic count_failure(input string msg);
        errors++;
        $display("Failure: %s at %0t", msg, $time);
    endtask

    task automatic load_tests();
        int          fd;
        int          got;
        string       line;
        string       kind_s;
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  s;
        logic [2:0]  z;
        txn_t        t;
        fd = $fopen("bridge_testdata.txt", "r");
        if (fd == 0) begin
            count_failure("cannot open bridge_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 1 && line[0] != "#") begin
                got = $sscanf(line, "%s %h %h %h %h", kind_s, a, d, s, z);
                if (got != 5) begin
                    count_failure("malformed line in bridge_testdata.txt");
                end else begin
                    t.kind = kind_s[0];
                    t.addr = a;
                    t.data = d;
                    t.strb = s;
                    t.size = z;
                    tests.push_back(t);
                    if (t.kind == "W" || t.kind == "P") n_writes++;
                    if (t.kind == "F" || t.kind == "P") n_fetches++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic fetch_burst(input logic [31:0] addr);
        i_if_addr = addr;
        i_if_req  = 1'b1;
        do @(negedge aclk); while (!o_if_rdy);
        @(posedge aclk);
        #1;
        i_if_req = 1'b0;
        do @(negedge aclk); while (!o_if_last);
        n_done++;
    endtask

    task automatic data_read(input logic [31:0] addr, input logic [2:0] size);
        i_drd_addr = addr;
        i_drd_size = size;
        i_drd_req  = 1'b1;
        do @(negedge aclk); while (!o_drd_rdy);
        @(posedge aclk);
        #1;
        i_drd_req = 1'b0;
        do @(negedge aclk); while (!o_drd_valid);
        n_done++;
    endtask

    task automatic data_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        i_dwr_addr = addr;
        i_dwr_data = data;
        i_dwr_strb = strb;
        i_dwr_req  = 1'b1;
        do @(negedge aclk); while (!o_dwr_rdy);
        @(posedge aclk);
        #1;
        i_dwr_req = 1'b0;
        do @(negedge aclk); while (!o_dwr_done);
        n_done++;
    endtask

    task automatic play_line(input txn_t t);
        case (t.kind)
            "F": begin
                exp_q.push_back(t);
                fetch_burst(t.addr);
            end
            "R": begin
                exp_q.push_back(t);
                data_read(t.addr, t.size);
            end
            "W": begin
                exp_q.push_back(t);
                data_write(t.addr, t.data, t.strb);
            end
            "P": begin
                // grant order must be write, read, fetch
                t.kind = "W";
                exp_q.push_back(t);
                t.kind = "R";
                exp_q.push_back(t);
                t.kind = "F";
                exp_q.push_back(t);
                fork
                    data_write(t.addr, t.data, t.strb);
                    data_read(t.addr, t.size);
                    fetch_burst(t.addr);
                join
            end
            default: count_failure("unknown transaction kind in test data");
        endcase
    endtask

    // monitor and slave bookkeeping for the handshakes of the coming edge
    always @(negedge aclk) begin
        if (aresetn) begin
            ar_hs = o_arvalid && i_arready;
            r_hs  = i_rvalid && o_rready;
            aw_hs = o_awvalid && i_awready;
            w_hs  = o_wvalid && i_wready;
            b_hs  = i_bvalid && o_bready;

            if (ar_stall && (!o_arvalid || ar_snap != {o_arid, o_araddr, o_arlen,
                                                       o_arsize, o_arprot}))
                count_failure("AR valid or fields changed while arready was low");
            if (aw_stall && (!o_awvalid || aw_snap != {o_awaddr, o_awlen}))
                count_failure("AW valid or fields changed while awready was low");

            if (o_if_valid !== (r_hs && cur.kind == "F"))
                report_mismatch("o_if_valid", o_if_valid, r_hs && cur.kind == "F");
            if (o_drd_valid !== (r_hs && cur.kind == "R"))
                report_mismatch("o_drd_valid", o_drd_valid, r_hs && cur.kind == "R");
            exp_last = r_hs && cur.kind == "F" && beat_idx == IF_BEATS - 1;
            if (o_if_last !== exp_last)
                report_mismatch("o_if_last", o_if_last, exp_last);
            if (r_hs) begin
                exp_rd = (cur.addr + 32'(4 * beat_idx)) ^ RD_MASK;
                if (cur.kind == "F") begin
                    if (o_if_data !== exp_rd)
                        report_mismatch("o_if_data", o_if_data, exp_rd);
                    fetch_beats++;
                end else if (o_drd_data !== exp_rd) begin
                    report_mismatch("o_drd_data", o_drd_data, exp_rd);
                end
                beat_idx++;
                rd_addr = rd_addr + 32'd4;
                rd_left--;
                r_wait = $urandom % 4;
            end else if (rd_left != 0 && r_wait != 0) begin
                r_wait--;
            end

            if (ar_hs) begin
                if (exp_q.size() == 0 || exp_q[0].kind == "W") begin
                    count_failure("read address handshake when no read was due");
                end else begin
                    cur = exp_q.pop_front();
                    beat_idx = 0;
                    if (o_araddr !== cur.addr) report_mismatch("o_araddr", o_araddr, cur.addr);
                    if (cur.kind == "F") begin
                        if (o_arid !== 4'd0) report_mismatch("o_arid", o_arid, 0);
                        if (o_arlen !== FETCH_LEN)
                            report_mismatch("o_arlen", o_arlen, FETCH_LEN);
                        if (o_arsize !== 3'b010) report_mismatch("o_arsize", o_arsize, 3'b010);
                        if (o_arprot !== 3'b100) report_mismatch("o_arprot", o_arprot, 3'b100);
                    end else begin
                        if (o_arid !== 4'd1) report_mismatch("o_arid", o_arid, 1);
                        if (o_arlen !== '0) report_mismatch("o_arlen", o_arlen, 0);
                        if (o_arsize !== cur.size)
                            report_mismatch("o_arsize", o_arsize, cur.size);
                        if (o_arprot !== 3'b000) report_mismatch("o_arprot", o_arprot, 0);
                    end
                end
                rd_addr = o_araddr;
                rd_left = int'(o_arlen) + 1;
                rd_id   = o_arid;
                r_wait  = $urandom % 4;
                ar_wait = $urandom % 4;
            end else if (o_arvalid && ar_wait != 0) begin
                ar_wait--;
            end

            if (o_dwr_done !== b_hs) report_mismatch("o_dwr_done", o_dwr_done, b_hs);
            if (o_dwr_done) dwr_done_cnt++;
            if (b_hs) begin
                if (aw_rec !== wr_cur.addr)
                    report_mismatch("o_awaddr", aw_rec, wr_cur.addr);
                if (w_data_rec !== wr_cur.data)
                    report_mismatch("o_wdata", w_data_rec, wr_cur.data);
                if (w_strb_rec !== wr_cur.strb)
                    report_mismatch("o_wstrb", w_strb_rec, wr_cur.strb);
                b_pend = 1'b0;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end else if (b_pend && b_wait != 0) begin
                b_wait--;
            end

            if (aw_hs) begin
                if (exp_q.size() == 0 || exp_q[0].kind != "W") begin
                    count_failure("write address handshake when no write was due");
                end else begin
                    wr_cur = exp_q.pop_front();
                end
                if (o_awlen !== '0) report_mismatch("o_awlen", o_awlen, 0);
                aw_rec  = o_awaddr;
                aw_got  = 1'b1;
                aw_wait = $urandom % 4;
            end else if (o_awvalid && aw_wait != 0) begin
                aw_wait--;
            end

            if (w_hs) begin
                if (o_wlast !== 1'b1) report_mismatch("o_wlast", o_wlast, 1);
                w_data_rec = o_wdata;
                w_strb_rec = o_wstrb;
                w_got      = 1'b1;
                w_wait     = $urandom % 4;
            end else if (o_wvalid && w_wait != 0) begin
                w_wait--;
            end

            if (aw_got && w_got && !b_pend) begin
                b_pend = 1'b1;
                b_wait = $urandom % 4;
            end

            ar_stall = o_arvalid && !i_arready;
            ar_snap  = {o_arid, o_araddr, o_arlen, o_arsize, o_arprot};
            aw_stall = o_awvalid && !i_awready;
            aw_snap  = {o_awaddr, o_awlen};
        end
    end

    // slave outputs driven just after the rising edge
    always @(posedge aclk) begin
        #1;
        i_arready = aresetn && (ar_wait == 0);
        i_awready = aresetn && (aw_wait == 0);
        i_wready  = aresetn && (w_wait == 0);
        i_rvalid  = aresetn && (rd_left != 0) && (r_wait == 0);
        i_rid     = rd_id;
        i_rdata   = rd_addr ^ RD_MASK;
        i_rlast   = (rd_left == 1);
        i_bvalid  = aresetn && b_pend && (b_wait == 0);
    end

    initial begin
        wait (n_lines != 0);
        #((n_lines * 60 + 10) * 4);
        $display("Timeout: transactions still pending after %0d cycles per line", 60);
        $display("Test failed");
        $finish;
    end

    initial begin
        // first draw after seeding gives the initial AR gap
        ar_wait = $urandom(32'h7a14_9857) % 4;
        aresetn    = 1'b0;
        i_if_req   = 1'b0;
        i_if_addr  = '0;
        i_drd_req  = 1'b0;
        i_drd_addr = '0;
        i_drd_size = '0;
        i_dwr_req  = 1'b0;
        i_dwr_addr = '0;
        i_dwr_data = '0;
        i_dwr_strb = '0;
        i_arready  = 1'b0;
        i_awready  = 1'b0;
        i_wready   = 1'b0;
        i_rvalid   = 1'b0;
        i_rid      = '0;
        i_rdata    = '0;
        i_rresp    = 2'b00;
        i_rlast    = 1'b0;
        i_bresp    = 2'b00;
        i_bvalid   = 1'b0;
        rd_left = 0;
        rd_addr = '0;
        rd_id   = '0;
        aw_wait = 0;
        w_wait  = 0;
        r_wait  = 0;
        b_wait  = 0;
        aw_got  = 1'b0;
        w_got   = 1'b0;
        b_pend  = 1'b0;
        ar_stall = 1'b0;
        aw_stall = 1'b0;
        cur      = '0;
        load_tests();
        n_lines = tests.size();
        if (n_lines == 0) count_failure("no transactions read from bridge_testdata.txt");

        repeat (10) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(negedge aclk);
        if ({o_arvalid, o_awvalid, o_wvalid, o_rready, o_bready, o_if_rdy, o_drd_rdy,
             o_dwr_rdy, o_if_valid, o_if_last, o_drd_valid, o_dwr_done} !== '0)
            report_mismatch("valid, ready, rdy and done outputs after reset",
                            {o_arvalid, o_awvalid, o_wvalid, o_rready, o_bready, o_if_rdy,
                             o_drd_rdy, o_dwr_rdy, o_if_valid, o_if_last, o_drd_valid,
                             o_dwr_done}, 0);

        foreach (tests[i]) begin
            @(posedge aclk);
            #1;
            play_line(tests[i]);
        end
        repeat (4) @(negedge aclk);

        if (exp_q.size() != 0) count_failure("some expected address handshakes never came");
        if (dwr_done_cnt != n_writes)
            report_mismatch("o_dwr_done pulses", dwr_done_cnt, n_writes);
        if (fetch_beats != n_fetches * IF_BEATS)
            report_mismatch("fetch beats", fetch_beats, n_fetches * IF_BEATS);

        $display("Summary: %0d transactions done, %0d errors", n_done, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* bridge_testdata.txt */
# kind addr wdata strb size, all hex
# kind F fetch burst, R data read, W data write, P all three raised together
F 00001000 00000000 0 2
R 00002004 00000000 0 2
W 00003008 deadbeef f 2
R 00002102 00000000 0 1
W 0000300c 12345678 3 2
R 00002203 00000000 0 0
F 00001040 00000000 0 2
W 00003010 a5a5a5a5 c 2
P 00004000 cafef00d 5 2
R 00002300 00000000 0 2
W 00003014 0badc0de 1 2
F 00001080 00000000 0 2
R 00002406 00000000 0 1
W 00003018 f00dface 8 2
P 00005040 13572468 a 2

/* files.f */
axi_bridge_pkg.sv
bus_ctrl_if.sv
chan_hold.sv
beat_counter.sv
read_router.sv
bus_owner_fsm.sv
core_axi_bridge.sv
tb_core_axi_bridge.sv

/* run.sh */
#!/bin/sh
# build and run the bridge testbench with Verilator, pass is found in sim.log
verilator --binary --assert -Wno-fatal --top-module tb_core_axi_bridge \
    -f files.f -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    || { echo "build or simulation did not run"; exit 1; }
grep -q "Test completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
